/* hdl/counter_snapshot_bank.sv */
////////////////////
// Counter snapshot bank
////////////////////

`timescale 1ns/1ns
`default_nettype none

module counter_snapshot_bank
    import stats_cnt_pkg::*;
(
    input  logic                            clk_ifc,
    input  logic                            peripheral_sresetn_core,

    // Counter-control register, one level per port
    input  port_mask_t                      sample_req,

    input  port_counts_t [num_ports-1:0]    live_counts,
    input  cnt_t [num_ports-1:0]            drop_counts,

    // Load strobe, also clears the drop counters
    output port_mask_t                      sample_now,

    output port_snapshot_t [num_ports-1:0]  snapshots
);

    port_mask_t sample_req_q;

    ////////////////////
    // Request edge detect

    // Holding a bit high does not sample again
    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_req_q <= '0;
            sample_now   <= '0;
        end else begin
            sample_req_q <= sample_req;
            sample_now   <= sample_req & ~sample_req_q;
        end
    end

    ////////////////////
    // Snapshot registers

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            snapshots <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (sample_now[p]) begin
                    snapshots[p] <= '{
                        pkts:  live_counts[p].pkts,
                        bytes: live_counts[p].bytes,
                        errs:  live_counts[p].errs,
                        drops: drop_counts[p]
                    };
                end
            end
        end
    end

    // One load per rising edge of a request bit
    for (genvar p = 0; p < num_ports; p++) begin : g_pulse_check
        a_single_pulse : assert property (
            @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
            sample_now[p] |=> !sample_now[p]
        );
    end

endmodule

`default_nettype wire

/* hdl/drop_event_counter.sv */
////////////////////
// Buffer-full drop counters
////////////////////

`timescale 1ns/1ns
`default_nettype none

module drop_event_counter
    import stats_cnt_pkg::*;
(
    input  logic                        clk_ifc,
    input  logic                        peripheral_sresetn_core,

    // Level per port, one event per rising edge
    input  port_mask_t                  buf_full_drop,

    // Clear pulse from the snapshot bank
    input  port_mask_t                  sample_now,

    output cnt_t [num_ports-1:0]        drop_counts
);

    port_mask_t drop_q;
    port_mask_t drop_edge;

    ////////////////////
    // Edge detect

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_q <= '0;
        end else begin
            drop_q <= buf_full_drop;
        end
    end

    assign drop_edge = buf_full_drop & ~drop_q;

    ////////////////////
    // Counters

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_counts <= '0;
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (sample_now[p]) begin
                    // An edge in the sample cycle opens the new period
                    drop_counts[p] <= drop_edge[p] ? cnt_t'(1) : '0;
                end else if (drop_edge[p]) begin
                    drop_counts[p] <= drop_counts[p] + cnt_t'(1);
                end
            end
        end
    end

    // Software must sample before a port's count runs out
    for (genvar p = 0; p < num_ports; p++) begin : g_wrap_check
        a_no_wrap : assert property (
            @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
            (drop_edge[p] && !sample_now[p]) |-> (drop_counts[p] != '1)
        );
    end

endmodule

`default_nettype wire

/* hdl/port_stats_regs.sv */
////////////////////
// Port statistics registers
////////////////////

`timescale 1ns/1ns
`default_nettype none

module port_stats_regs
    import stats_cnt_pkg::*;
    import stats_regs_pkg::*;
(
    input  logic                            clk_ifc,
    input  logic                            peripheral_sresetn_core,

    // Register bus
    input  bus_req_t                        bus_req,
    output bus_rsp_t                        bus_rsp,

    // Packet path
    input  port_counts_t [num_ports-1:0]    live_counts,
    input  port_mask_t                      buf_full_drop,
    output port_mask_t                      ports_enable
);

    port_mask_t                     sample_req;
    port_mask_t                     sample_now;
    cnt_t [num_ports-1:0]           drop_counts;
    port_snapshot_t [num_ports-1:0] snapshots;

    ////////////////////
    // Drop event counting

    drop_event_counter i_drop_event_counter (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .buf_full_drop           ( buf_full_drop           ),
        .sample_now              ( sample_now              ),
        .drop_counts             ( drop_counts             )
    );

    ////////////////////
    // Snapshots

    counter_snapshot_bank i_counter_snapshot_bank (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample_req              ( sample_req              ),
        .live_counts             ( live_counts             ),
        .drop_counts             ( drop_counts             ),
        .sample_now              ( sample_now              ),
        .snapshots               ( snapshots               )
    );

    ////////////////////
    // Bus side

    stats_reg_access i_stats_reg_access (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .bus_rsp                 ( bus_rsp                 ),
        .snapshots               ( snapshots               ),
        .sample_req              ( sample_req              ),
        .ports_enable            ( ports_enable            )
    );

endmodule

`default_nettype wire

/* hdl/stats_cnt_pkg.sv */
////////////////////
// Port counter types
////////////////////

`default_nettype none

package stats_cnt_pkg;

    ////////////////////
    // Sizes

    // Physical ingress ports
    localparam int num_ports = 8;
    localparam int port_idx_width = $clog2(num_ports);

    localparam int cnt_width = 32;

    // Snapshot words kept for each port
    localparam int cnts_per_port = 4;
    localparam int cnt_sel_width = $clog2(cnts_per_port);

    ////////////////////
    // Types

    // One bit per port
    typedef logic [num_ports-1:0] port_mask_t;

    typedef logic [cnt_width-1:0] cnt_t;

    // Live counts driven by the packet path
    typedef struct packed {
        cnt_t pkts;
        cnt_t bytes;
        cnt_t errs;
    } port_counts_t;

    // Member order matches the register order within a port
    typedef struct packed {
        cnt_t pkts;
        cnt_t bytes;
        cnt_t errs;
        cnt_t drops;
    } port_snapshot_t;

    // Word position inside one port's block
    typedef enum logic [cnt_sel_width-1:0] {
        CNT_PKT,
        CNT_BYTE,
        CNT_ERR,
        CNT_DROP
    } cnt_sel_e;

endpackage

`default_nettype wire

/* hdl/stats_reg_access.sv */
////////////////////
// Register access
////////////////////

`timescale 1ns/1ns
`default_nettype none

module stats_reg_access
    import stats_cnt_pkg::*;
    import stats_regs_pkg::*;
(
    input  logic                            clk_ifc,
    input  logic                            peripheral_sresetn_core,

    input  bus_req_t                        bus_req,
    output bus_rsp_t                        bus_rsp,

    input  port_snapshot_t [num_ports-1:0]  snapshots,

    output port_mask_t                      sample_req,
    output port_mask_t                      ports_enable
);

    port_mask_t enable_con;
    port_mask_t enable_stat;
    port_mask_t counter_con;

    logic                       rsp_valid;
    logic [data_width-1:0]      rsp_data;
    logic [data_width-1:0]      rd_word;

    logic                       cnt_hit;
    logic [addr_width-1:0]      cnt_offset;
    logic [port_idx_width-1:0]  cnt_port;
    cnt_sel_e                   cnt_sel;

    ////////////////////
    // Control registers

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            enable_con  <= '1;
            enable_stat <= '1;
            counter_con <= '0;
        end else begin
            // Status lags control by one cycle
            enable_stat <= enable_con;

            if (bus_req.cmd == CMD_WRITE) begin
                if (bus_req.addr == ADDR_PORT_ENABLE_CON) begin
                    enable_con <= bus_req.wr_data[num_ports-1:0];
                end else if (bus_req.addr == ADDR_COUNTER_CON) begin
                    counter_con <= bus_req.wr_data[num_ports-1:0];
                end
            end
        end
    end

    assign ports_enable = enable_con;
    assign sample_req   = counter_con;

    ////////////////////
    // Read mux

    // Snapshot words are laid out port by port, four words each
    assign cnt_hit    = (bus_req.addr >= ADDR_COUNTERS_START) &&
                        (int'(bus_req.addr) < total_regs);
    assign cnt_offset = bus_req.addr - ADDR_COUNTERS_START;
    assign cnt_port   = cnt_offset[cnt_sel_width +: port_idx_width];
    assign cnt_sel    = cnt_sel_e'(cnt_offset[cnt_sel_width-1:0]);

    always_comb begin
        rd_word = '0;
        case (bus_req.addr)
            ADDR_VERSION_ID:       rd_word = version_id_val;
            ADDR_PORT_ENABLE_CON:  rd_word = data_width'(enable_con);
            ADDR_PORT_ENABLE_STAT: rd_word = data_width'(enable_stat);
            ADDR_COUNTER_CON:      rd_word = data_width'(counter_con);
            default: begin
                // Unmapped addresses stay zero
                if (cnt_hit) begin
                    case (cnt_sel)
                        CNT_PKT:  rd_word = snapshots[cnt_port].pkts;
                        CNT_BYTE: rd_word = snapshots[cnt_port].bytes;
                        CNT_ERR:  rd_word = snapshots[cnt_port].errs;
                        CNT_DROP: rd_word = snapshots[cnt_port].drops;
                        default:  rd_word = '0;
                    endcase
                end
            end
        endcase
    end

    ////////////////////
    // Response

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (bus_req.cmd == CMD_READ);
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (bus_req.cmd == CMD_READ) begin
            rsp_data <= rd_word;
        end
    end

    assign bus_rsp = '{rd_valid: rsp_valid, rd_data: rsp_data};

    // Fixed read latency of one cycle, in both directions
    a_read_rsp : assert property (
        @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        (bus_req.cmd == CMD_READ) |=> rsp_valid
    );

    a_rsp_from_read : assert property (
        @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        rsp_valid |-> $past(bus_req.cmd == CMD_READ)
    );

endmodule

`default_nettype wire

/* hdl/stats_regs_pkg.sv */
////////////////////
// Register map and bus types
////////////////////

`default_nettype none

package stats_regs_pkg;
    import stats_cnt_pkg::*;

    localparam int data_width = 32;

    // Word address
    localparam int addr_width = 8;

    ////////////////////
    // Identification

    // Version 1.0
    localparam logic [15:0] module_version = {8'd1, 8'd0};
    localparam logic [15:0] module_id = 16'd10;

    localparam logic [data_width-1:0] version_id_val = {module_version, module_id};

    ////////////////////
    // Register map

    typedef enum logic [addr_width-1:0] {
        ADDR_VERSION_ID       = 8'd0,
        ADDR_PORT_ENABLE_CON  = 8'd1,
        ADDR_PORT_ENABLE_STAT = 8'd2,
        ADDR_COUNTER_CON      = 8'd3,
        ADDR_COUNTERS_START   = 8'd4
    } reg_addr_e;

    // Four control words, then one block of snapshot words per port
    localparam int total_regs = ADDR_COUNTERS_START + num_ports * cnts_per_port;

    ////////////////////
    // Bus

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_READ,
        CMD_WRITE
    } bus_cmd_e;

    typedef struct packed {
        bus_cmd_e               cmd;
        logic [addr_width-1:0]  addr;
        logic [data_width-1:0]  wr_data;
    } bus_req_t;

    typedef struct packed {
        logic                   rd_valid;
        logic [data_width-1:0]  rd_data;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* port_stats_regs.f */
+incdir+tests
hdl/stats_cnt_pkg.sv
hdl/stats_regs_pkg.sv
hdl/drop_event_counter.sv
hdl/counter_snapshot_bank.sv
hdl/stats_reg_access.sv
hdl/port_stats_regs.sv
tests/port_stats_regs_tb.sv

/* tests/stats_vectors.svh */
////////////////////
// Test vector table
////////////////////

`ifndef stats_vectors_svh
`define stats_vectors_svh

typedef enum logic [2:0] {
    OP_READ,
    OP_WRITE,
    OP_LIVE,
    OP_DROP,
    OP_EN_CHECK
} vec_op_e;

// One step of the run
typedef struct packed {
    vec_op_e                        op;
    logic [addr_width-1:0]          addr;
    logic [data_width-1:0]          data;
    int                             port;
    int                             count;
    port_counts_t [num_ports-1:0]   live;
    logic [data_width-1:0]          expected;
} vec_row_t;

vec_row_t vectors[$];

task automatic build_table();
    // Reset values
    expect_read(ADDR_VERSION_ID);
    expect_read(ADDR_PORT_ENABLE_CON);
    expect_read(ADDR_PORT_ENABLE_STAT);
    expect_read(ADDR_COUNTER_CON);
    expect_all_snapshots();
    expect_enable();

    // Port enable, then writes that must be ignored
    add_write(ADDR_PORT_ENABLE_CON, 32'h0000_00a5);
    expect_enable();
    expect_read(ADDR_PORT_ENABLE_CON);
    expect_read(ADDR_PORT_ENABLE_STAT);
    add_write(ADDR_PORT_ENABLE_STAT, 32'h0000_003c);
    add_write(ADDR_VERSION_ID, 32'hdead_beef);
    expect_read(ADDR_VERSION_ID);
    expect_read(ADDR_PORT_ENABLE_STAT);
    expect_enable();
    expect_read(total_regs);
    expect_read(8'hff);

    // Sample half the ports, then move the live values on
    new_live_counts();
    add_write(ADDR_COUNTER_CON, 32'h0000_005a);
    expect_read(ADDR_COUNTER_CON);
    expect_all_snapshots();
    new_live_counts();
    expect_all_snapshots();

    // Held bits do not resample, a bit that rises again does
    add_write(ADDR_COUNTER_CON, 32'h0000_005a);
    expect_all_snapshots();
    add_write(ADDR_COUNTER_CON, 32'h0000_0058);
    add_write(ADDR_COUNTER_CON, 32'h0000_005a);
    expect_all_snapshots();

    // Port p sees p+1 drop events
    add_write(ADDR_COUNTER_CON, 32'h0);
    for (int p = 0; p < num_ports; p++) begin
        add_drop_pulses(p, p + 1);
    end
    add_write(ADDR_COUNTER_CON, 32'h0000_00ff);
    expect_all_snapshots();
    add_write(ADDR_COUNTER_CON, 32'h0);
    add_write(ADDR_COUNTER_CON, 32'h0000_00ff);
    expect_all_snapshots();
endtask

`endif

/* tests/port_stats_regs_tb.sv */
////////////////////
// Port statistics testbench
////////////////////

`timescale 1ns/1ns
`default_nettype none

module port_stats_regs_tb
    import stats_cnt_pkg::*;
    import stats_regs_pkg::*;
();

    localparam int rsp_timeout = 10;
    // Idle cycles after a write, so counter-control has loaded the snapshots
    localparam int write_settle = 2;

    logic                           clk_ifc;
    logic                           peripheral_sresetn_core;
    bus_req_t                       bus_req;
    bus_rsp_t                       bus_rsp;
    port_counts_t [num_ports-1:0]   live_counts;
    port_mask_t                     buf_full_drop;
    port_mask_t                     ports_enable;

    // Expected register contents
    port_mask_t                     model_en;
    port_mask_t                     model_ctrl;
    port_counts_t [num_ports-1:0]   model_live;
    cnt_t [num_ports-1:0]           model_drops;
    port_snapshot_t [num_ports-1:0] model_snap;

    `include "stats_vectors.svh"

    port_stats_regs i_port_stats_regs (
        .clk_ifc                 ( clk_ifc                 ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .bus_req                 ( bus_req                 ),
        .bus_rsp                 ( bus_rsp                 ),
        .live_counts             ( live_counts             ),
        .buf_full_drop           ( buf_full_drop           ),
        .ports_enable            ( ports_enable            )
    );

    initial begin
        clk_ifc = 1'b0;
        forever #10 clk_ifc = ~clk_ifc;
    end

    ////////////////////
    // Table building

    function automatic logic [data_width-1:0] model_read(input int addr);
        int p;
        int w;
        logic [data_width-1:0] value;
        p = (addr - ADDR_COUNTERS_START) / cnts_per_port;
        w = (addr - ADDR_COUNTERS_START) % cnts_per_port;
        value = '0;
        if (addr == ADDR_VERSION_ID) begin
            value = version_id_val;
        end else if (addr == ADDR_PORT_ENABLE_CON || addr == ADDR_PORT_ENABLE_STAT) begin
            value = data_width'(model_en);
        end else if (addr == ADDR_COUNTER_CON) begin
            value = data_width'(model_ctrl);
        end else if (addr >= ADDR_COUNTERS_START && addr < total_regs) begin
            case (w)
                0: value = model_snap[p].pkts;
                1: value = model_snap[p].bytes;
                2: value = model_snap[p].errs;
                default: value = model_snap[p].drops;
            endcase
        end
        return value;
    endfunction

    task automatic expect_read(input int addr);
        vec_row_t row;
        row = '0;
        row.op = OP_READ;
        row.addr = addr[addr_width-1:0];
        row.expected = model_read(addr);
        vectors.push_back(row);
    endtask

    task automatic expect_all_snapshots();
        for (int a = ADDR_COUNTERS_START; a < total_regs; a++) begin
            expect_read(a);
        end
    endtask

    task automatic add_write(input int addr, input logic [data_width-1:0] data);
        vec_row_t row;
        port_mask_t rising;
        row = '0;
        row.op = OP_WRITE;
        row.addr = addr[addr_width-1:0];
        row.data = data;
        vectors.push_back(row);
        if (addr == ADDR_PORT_ENABLE_CON) begin
            model_en = data[num_ports-1:0];
        end else if (addr == ADDR_COUNTER_CON) begin
            // Only a bit going from 0 to 1 takes a snapshot
            rising = data[num_ports-1:0] & ~model_ctrl;
            for (int p = 0; p < num_ports; p++) begin
                if (rising[p]) begin
                    model_snap[p].pkts = model_live[p].pkts;
                    model_snap[p].bytes = model_live[p].bytes;
                    model_snap[p].errs = model_live[p].errs;
                    model_snap[p].drops = model_drops[p];
                    model_drops[p] = '0;
                end
            end
            model_ctrl = data[num_ports-1:0];
        end
    endtask

    task automatic new_live_counts();
        vec_row_t row;
        row = '0;
        row.op = OP_LIVE;
        for (int p = 0; p < num_ports; p++) begin
            row.live[p].pkts = $urandom();
            row.live[p].bytes = $urandom();
            row.live[p].errs = $urandom();
        end
        model_live = row.live;
        vectors.push_back(row);
    endtask

    task automatic add_drop_pulses(input int port, input int count);
        vec_row_t row;
        row = '0;
        row.op = OP_DROP;
        row.port = port;
        row.count = count;
        model_drops[port] = model_drops[port] + cnt_t'(count);
        vectors.push_back(row);
    endtask

    task automatic expect_enable();
        vec_row_t row;
        row = '0;
        row.op = OP_EN_CHECK;
        row.expected = data_width'(model_en);
        vectors.push_back(row);
    endtask

    ////////////////////
    // Applying rows

    task automatic check_word(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
        assert (actual === expected) else begin
            $display("[ERROR] %0t ns: %s expected 0x%08h, actual 0x%08h",
                     $time, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input vec_row_t row);
        bit got_rsp;
        got_rsp = 1'b0;
        case (row.op)
            OP_READ: begin
                bus_req = '{cmd: CMD_READ, addr: row.addr, wr_data: '0};
                for (int i = 0; i < rsp_timeout && !got_rsp; i++) begin
                    @(negedge clk_ifc);
                    bus_req.cmd = CMD_IDLE;
                    got_rsp = bus_rsp.rd_valid;
                end
                assert (got_rsp) else begin
                    $display("rsp_valid never came for the read of address %0d", row.addr);
                    $display("tests failed");
                    $fatal(1);
                end
                check_word($sformatf("bus_rsp.rd_data (address %0d)", row.addr),
                           row.expected, bus_rsp.rd_data);
            end
            OP_WRITE: begin
                bus_req = '{cmd: CMD_WRITE, addr: row.addr, wr_data: row.data};
                @(negedge clk_ifc);
                bus_req.cmd = CMD_IDLE;
                repeat (write_settle) @(negedge clk_ifc);
            end
            OP_LIVE: begin
                live_counts = row.live;
                @(negedge clk_ifc);
            end
            OP_DROP: begin
                // One cycle high and one low per event
                for (int k = 0; k < row.count; k++) begin
                    buf_full_drop[row.port] = 1'b1;
                    @(negedge clk_ifc);
                    buf_full_drop[row.port] = 1'b0;
                    @(negedge clk_ifc);
                end
            end
            OP_EN_CHECK: begin
                check_word("ports_enable", row.expected, data_width'(ports_enable));
            end
            default: begin
            end
        endcase
    endtask

    initial begin
        peripheral_sresetn_core = 1'b0;
        bus_req = '{cmd: CMD_IDLE, addr: '0, wr_data: '0};
        live_counts = '0;
        buf_full_drop = '0;
        model_en = '1;
        model_ctrl = '0;
        model_live = '0;
        model_drops = '0;
        model_snap = '0;
        void'($urandom(32'h9013_2b97));
        build_table();

        repeat (2) @(negedge clk_ifc);
        peripheral_sresetn_core = 1'b1;

        foreach (vectors[i]) begin
            apply_row(vectors[i]);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
